/* source/mem_sys_pkg.sv */
package mem_sys_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int addr_w           = 16;
    localparam int data_w           = 16;
    localparam int tag_w            = 5;
    localparam int index_w          = 8;
    localparam int offset_w         = 3;
    localparam int num_banks        = 4;      // One bank per word of a line
    localparam int mem_latency      = 2;
    localparam int bank_busy_cycles = 4;
    localparam int mem_words        = 32768;

    localparam int lines      = 2 ** index_w;  // Lines per way
    localparam int bank_rows  = mem_words / num_banks;
    localparam int row_w      = $clog2(bank_rows);
    localparam int busy_cnt_w = $clog2(bank_busy_cycles + 1);

    // Controller state codes
    localparam logic [3:0] st_idle   = 4'd0;
    localparam logic [3:0] st_retry  = 4'd1;
    localparam logic [3:0] st_done   = 4'd2;
    localparam logic [3:0] st_push_0 = 4'd3;
    localparam logic [3:0] st_push_1 = 4'd4;
    localparam logic [3:0] st_push_2 = 4'd5;
    localparam logic [3:0] st_push_3 = 4'd6;
    localparam logic [3:0] st_pull_0 = 4'd7;
    localparam logic [3:0] st_pull_1 = 4'd8;
    localparam logic [3:0] st_pull_2 = 4'd9;
    localparam logic [3:0] st_pull_3 = 4'd10;
    localparam logic [3:0] st_pull_4 = 4'd11;
    localparam logic [3:0] st_pull_5 = 4'd12;
    localparam logic [3:0] st_pull_6 = 4'd13;

    // Flat view for the banked memory, field view for the cache
    typedef union packed {
        logic [addr_w-1:0] flat;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;    // Bit 0 ignored
        } f;
    } mem_addr_t;

endpackage

/* source/request_latch.sv */
`timescale 1ns/1ps

module request_latch import mem_sys_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd,
    input  logic              wr,
    input  mem_addr_t         addr,
    input  logic [data_w-1:0] data_in,
    input  logic              done,
    output logic              req_rd,
    output logic              req_wr,
    output mem_addr_t         req_addr,
    output logic [data_w-1:0] req_data,
    output logic              busy_req
);

    logic capture;

    assign busy_req = req_rd | req_wr;
    assign capture  = (rd | wr) & ~busy_req;   // Strobes during a held request are dropped

    always_ff @(posedge clk) begin
        if (reset) begin
            req_rd <= 1'b0;
            req_wr <= 1'b0;
        end else if (done) begin
            req_rd <= 1'b0;
            req_wr <= 1'b0;
        end else if (capture) begin
            req_rd <= rd;
            req_wr <= wr & ~rd;    // Load wins if both fire
        end
    end

    // Address and store data
    always_ff @(posedge clk) begin
        if (capture) begin
            req_addr <= addr;
            req_data <= data_in;
        end
    end

endmodule

/* source/cache_way.sv */
`timescale 1ns/1ps

module cache_way import mem_sys_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  logic               comp,
    input  logic               write,
    input  logic               valid_in,
    input  logic [index_w-1:0] index,
    input  logic [tag_w-1:0]   tag_in,
    input  logic [1:0]         word,
    input  logic [data_w-1:0]  wr_data,
    output logic               hit,
    output logic               valid,
    output logic               dirty,
    output logic [tag_w-1:0]   tag_out,
    output logic [data_w-1:0]  rd_data
);

    logic [tag_w-1:0]  tag_mem   [lines];
    logic [data_w-1:0] data_mem  [lines][num_banks];
    logic [lines-1:0]  valid_mem;
    logic [lines-1:0]  dirty_mem;

    logic fill_wr;     // Line install from memory
    logic comp_wr;     // Store into a hitting line

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////
    assign tag_out = tag_mem[index];
    assign valid   = valid_mem[index];
    assign dirty   = dirty_mem[index];
    assign rd_data = data_mem[index][word];
    assign hit     = enable & valid & (tag_out == tag_in);

    assign fill_wr = enable & write & ~comp;
    assign comp_wr = enable & write & comp & hit;

    ////////////////////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////////////////////

    // Line state bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_mem <= '0;
            dirty_mem <= '0;
        end else if (fill_wr) begin
            valid_mem[index] <= valid_in;
            dirty_mem[index] <= 1'b0;     // Fresh copy of memory
        end else if (comp_wr) begin
            dirty_mem[index] <= 1'b1;
        end
    end

    // Tags only change on a fill
    always_ff @(posedge clk) begin
        if (fill_wr) begin
            tag_mem[index] <= tag_in;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_wr || comp_wr) begin
            data_mem[index][word] <= wr_data;
        end
    end

endmodule

/* source/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller import mem_sys_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_rd,
    input  logic              req_wr,
    input  mem_addr_t         req_addr,
    input  logic [data_w-1:0] req_data,
    input  logic              hit_c0,
    input  logic              hit_c1,
    input  logic              valid_c0,
    input  logic              valid_c1,
    input  logic              dirty_c0,
    input  logic              dirty_c1,
    input  logic [tag_w-1:0]  tag_c0,
    input  logic [tag_w-1:0]  tag_c1,
    input  logic [data_w-1:0] rd_data_c0,
    input  logic [data_w-1:0] rd_data_c1,
    input  logic [3:0]        busy,
    input  logic [data_w-1:0] mem_rd_data,
    output logic              enable_c0,
    output logic              enable_c1,
    output logic              comp,
    output logic              write,
    output logic              valid_in,
    output logic [1:0]        word_c,
    output logic [data_w-1:0] wr_data,
    output logic              mem_rd,
    output logic              mem_wr,
    output mem_addr_t         mem_addr,
    output logic [data_w-1:0] mem_wr_data,
    output logic              cache_hit,
    output logic              done,
    output logic [data_w-1:0] data_out
);

    logic [3:0] state;
    logic [3:0] next_state;
    logic       victim_way;
    logic       target;        // Way being pushed or filled
    logic       target_sel;
    logic       hit_q;         // Idle compare result
    logic       push_wait;     // Last push word already written
    logic       req;
    logic       any_hit;
    logic       victim_dirty;
    logic       in_push;
    logic       in_fill;
    logic [1:0] req_word;
    logic [1:0] word_m;        // Word of the line on the memory side

    assign req          = req_rd | req_wr;
    assign any_hit      = hit_c0 | hit_c1;
    assign req_word     = req_addr.f.offset[2:1];
    assign victim_dirty = valid_c0 & valid_c1 & (victim_way ? dirty_c1 : dirty_c0);
    assign target_sel   = !valid_c0 ? 1'b0 : (!valid_c1 ? 1'b1 : victim_way);
    assign in_push      = state inside {[st_push_0:st_push_3]};
    assign in_fill      = state inside {[st_pull_2:st_pull_5]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            victim_way <= 1'b0;
            target     <= 1'b0;
            hit_q      <= 1'b0;
            push_wait  <= 1'b0;
        end else begin
            state     <= next_state;
            push_wait <= (state == st_push_3) && (next_state == st_push_3);
            if (done) begin
                victim_way <= ~victim_way;
            end
            if (state == st_idle && req) begin
                target <= target_sel;
                hit_q  <= any_hit;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        enable_c0  = 1'b0;
        enable_c1  = 1'b0;
        comp       = 1'b0;
        write      = 1'b0;
        valid_in   = 1'b0;
        mem_rd     = 1'b0;
        mem_wr     = 1'b0;
        done       = 1'b0;
        word_c     = req_word;
        word_m     = req_word;
        next_state = state;

        case (state)
            st_idle: begin    // Compare both ways, store on a hit
                enable_c0 = req;
                enable_c1 = req;
                comp      = req;
                write     = req_wr;
                valid_in  = req;
                if (!req)              next_state = st_idle;
                else if (any_hit)      next_state = st_done;
                else if (victim_dirty) next_state = st_push_0;
                else                   next_state = st_pull_0;
            end
            st_retry: begin
                enable_c0  = 1'b1;
                enable_c1  = 1'b1;
                comp       = 1'b1;
                write      = req_wr;
                valid_in   = 1'b1;
                next_state = st_done;
            end
            st_done: begin
                enable_c0  = ~req_wr;  // Read port for the load result
                enable_c1  = ~req_wr;
                comp       = 1'b1;
                valid_in   = 1'b1;
                done       = 1'b1;
                next_state = st_idle;
            end
            st_push_0, st_push_1, st_push_2, st_push_3: begin
                enable_c0 = 1'b1;
                enable_c1 = 1'b1;
                word_m    = 2'(state - st_push_0);
                word_c    = word_m;
                mem_wr    = ~push_wait;
                if (state != st_push_3) next_state = state + 4'd1;
                else if (|busy)         next_state = st_push_3;
                else                    next_state = st_pull_0;
            end
            st_pull_0, st_pull_1: begin    // First two reads, no data back yet
                mem_rd     = 1'b1;
                word_m     = 2'(state - st_pull_0);
                next_state = state + 4'd1;
            end
            st_pull_2, st_pull_3, st_pull_4, st_pull_5: begin
                enable_c0  = ~target;
                enable_c1  = target;
                write      = 1'b1;
                valid_in   = 1'b1;
                word_c     = 2'(state - st_pull_2);   // Two words behind the reads
                word_m     = 2'(state - st_pull_0);
                mem_rd     = (state == st_pull_2) || (state == st_pull_3);
                next_state = state + 4'd1;
            end
            st_pull_6: begin
                next_state = (|busy) ? st_pull_6 : st_retry;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath steering
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        mem_addr.f.tag    = in_push ? (target ? tag_c1 : tag_c0) : req_addr.f.tag;
        mem_addr.f.index  = req_addr.f.index;
        mem_addr.f.offset = {word_m, 1'b0};
    end

    assign wr_data     = in_fill ? mem_rd_data : req_data;
    assign mem_wr_data = target ? rd_data_c1 : rd_data_c0;  // Victim line out
    assign data_out    = hit_c1 ? rd_data_c1 : rd_data_c0;
    assign cache_hit   = (state == st_done) & hit_q;

endmodule

/* source/four_bank_mem.sv */
`timescale 1ns/1ps

module four_bank_mem import mem_sys_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rd,
    input  logic                 wr,
    input  mem_addr_t            addr,
    input  logic [data_w-1:0]    data_in,
    output logic [data_w-1:0]    data_out,
    output logic [num_banks-1:0] busy
);

    logic [data_w-1:0]     bank_mem [num_banks][bank_rows];
    logic [data_w-1:0]     rd_pipe  [mem_latency];
    logic [busy_cnt_w-1:0] busy_cnt [num_banks];
    logic [1:0]            bank;
    logic [row_w-1:0]      row;

    // Consecutive words land in consecutive banks
    assign bank = addr.flat[2:1];
    assign row  = addr.flat[addr_w-1:3];

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_mem <= '{default: '0};
        end else if (wr) begin
            bank_mem[bank][row] <= data_in;
        end
    end

    // Read data walks through the latency stages
    always_ff @(posedge clk) begin
        rd_pipe[0] <= rd ? bank_mem[bank][row] : '0;
        for (int i = 1; i < mem_latency; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign data_out = rd_pipe[mem_latency-1];

    ////////////////////////////////////////////////////////////////////////////
    // Bank busy
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < num_banks; b++) begin
                busy_cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < num_banks; b++) begin
                if ((rd || wr) && bank == 2'(b)) begin
                    busy_cnt[b] <= busy_cnt_w'(bank_busy_cycles);  // Restart on access
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            busy[b] = (busy_cnt[b] != '0);
        end
    end

endmodule

/* source/mem_sys.sv */
`timescale 1ns/1ps

module mem_sys import mem_sys_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd,
    input  logic              wr,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] data_in,
    output logic [data_w-1:0] data_out,
    output logic              done,
    output logic              stall,
    output logic              cache_hit
);

    // Held request
    logic              req_rd;
    logic              req_wr;
    mem_addr_t         req_addr;
    logic [data_w-1:0] req_data;

    // Way side
    logic              hit_c0, hit_c1;
    logic              valid_c0, valid_c1;
    logic              dirty_c0, dirty_c1;
    logic [tag_w-1:0]  tag_c0, tag_c1;
    logic [data_w-1:0] rd_data_c0, rd_data_c1;
    logic              enable_c0, enable_c1;
    logic              comp, write, valid_in;
    logic [1:0]        word_c;
    logic [data_w-1:0] wr_data;

    // Memory side
    logic              mem_rd, mem_wr;
    mem_addr_t         mem_addr;
    logic [data_w-1:0] mem_wr_data;
    logic [data_w-1:0] mem_rd_data;
    logic [3:0]        busy;

    request_latch u_latch (
        .clk, .reset, .rd, .wr, .addr, .data_in, .done,
        .req_rd, .req_wr, .req_addr, .req_data,
        .busy_req (stall)
    );

    cache_way way0 (
        .clk, .reset, .enable (enable_c0), .comp, .write, .valid_in,
        .index (req_addr.f.index), .tag_in (req_addr.f.tag), .word (word_c), .wr_data,
        .hit (hit_c0), .valid (valid_c0), .dirty (dirty_c0),
        .tag_out (tag_c0), .rd_data (rd_data_c0)
    );

    cache_way way1 (
        .clk, .reset, .enable (enable_c1), .comp, .write, .valid_in,
        .index (req_addr.f.index), .tag_in (req_addr.f.tag), .word (word_c), .wr_data,
        .hit (hit_c1), .valid (valid_c1), .dirty (dirty_c1),
        .tag_out (tag_c1), .rd_data (rd_data_c1)
    );

    cache_controller u_ctrl (
        .clk, .reset, .req_rd, .req_wr, .req_addr, .req_data,
        .hit_c0, .hit_c1, .valid_c0, .valid_c1, .dirty_c0, .dirty_c1,
        .tag_c0, .tag_c1, .rd_data_c0, .rd_data_c1, .busy, .mem_rd_data,
        .enable_c0, .enable_c1, .comp, .write, .valid_in, .word_c, .wr_data,
        .mem_rd, .mem_wr, .mem_addr, .mem_wr_data,
        .cache_hit, .done, .data_out
    );

    four_bank_mem u_mem (
        .clk, .reset, .rd (mem_rd), .wr (mem_wr), .addr (mem_addr),
        .data_in (mem_wr_data), .data_out (mem_rd_data), .busy
    );

endmodule

/* verification/mem_sys_model.svh */
`ifndef mem_sys_model_svh
`define mem_sys_model_svh

// Expected memory image, one entry per word address
logic [data_w-1:0] ref_words [mem_words];

// Tag state of both ways plus the victim bit
logic [tag_w-1:0]  ref_tag   [2][lines];
logic              ref_valid [2][lines];
logic              ref_victim;

function automatic void clear_model();
    for (int i = 0; i < mem_words; i++) begin
        ref_words[i] = '0;                 // Memory starts at zero
    end
    for (int i = 0; i < lines; i++) begin
        ref_valid[0][i] = 1'b0;
        ref_valid[1][i] = 1'b0;
    end
    ref_victim = 1'b0;
endfunction

// Hit test plus line install on a miss
function automatic logic predict_hit(input logic [addr_w-1:0] a);
    mem_addr_t ma;
    logic      hit;
    logic      way;
    ma.flat = a;
    hit = (ref_valid[0][ma.f.index] && ref_tag[0][ma.f.index] == ma.f.tag) ||
          (ref_valid[1][ma.f.index] && ref_tag[1][ma.f.index] == ma.f.tag);
    if (!hit) begin
        if (!ref_valid[0][ma.f.index]) way = 1'b0;      // Empty way 0 first
        else if (!ref_valid[1][ma.f.index]) way = 1'b1;
        else way = ref_victim;
        ref_valid[way][ma.f.index] = 1'b1;
        ref_tag[way][ma.f.index]   = ma.f.tag;
    end
    ref_victim = ~ref_victim;              // Flips at every done
    return hit;
endfunction

function automatic void reference_access(input logic is_wr, input logic [addr_w-1:0] a,
                                         input logic [data_w-1:0] d,
                                         output logic [data_w-1:0] exp_data,
                                         output logic exp_hit);
    exp_hit = predict_hit(a);
    if (is_wr) begin
        ref_words[a[addr_w-1:1]] = d;
        exp_data = d;
    end else begin
        exp_data = ref_words[a[addr_w-1:1]];   // Last store or zero
    end
endfunction

`endif

/* verification/mem_sys_tb.sv */
`timescale 1ns/1ps

module mem_sys_tb import mem_sys_pkg::*; ();

    localparam int clk_period        = 100;
    localparam int reset_cycles      = 10;
    localparam int idle_cycles       = 5;
    localparam int access_limit      = 40;   // Cycles allowed per access
    localparam int directed_accesses = 23;
    localparam int random_accesses   = 400;
    localparam int total_accesses    = directed_accesses + random_accesses;
    localparam int watchdog_cycles   = reset_cycles + 2 * idle_cycles +
                                       access_limit * total_accesses;

    logic              clk;
    logic              reset;
    logic              rd;
    logic              wr;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data_in;
    logic [data_w-1:0] data_out;
    logic              done;
    logic              stall;
    logic              cache_hit;

    typedef struct packed {
        logic              is_wr;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic              hit;
        logic              timed;      // Hit latency checked as well
        logic [63:0]       strobe_t;
    } expect_t;

    expect_t expect_q [$];
    expect_t head;
    int      issued     = 0;
    int      done_count = 0;
    int      seed       = 32'h0cbf_43d0;
    int      latency;

    `include "mem_sys_model.svh"

    mem_sys dut0 (
        .clk, .reset, .rd, .wr, .addr, .data_in,
        .data_out, .done, .stall, .cache_hit
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic logic [addr_w-1:0] make_addr(input int tag, input int index, input int w);
        mem_addr_t ma;
        ma.f.tag    = tag_w'(tag);
        ma.f.index  = index_w'(index);
        ma.f.offset = {2'(w), 1'b0};
        return ma.flat;
    endfunction

    // One strobe, then wait for its done
    task automatic run_access(input logic is_wr, input logic [addr_w-1:0] a,
                              input logic [data_w-1:0] d, input logic timed);
        expect_t e;
        int      waited;
        e.is_wr = is_wr;
        e.addr  = a;
        e.timed = timed;
        reference_access(is_wr, a, d, e.data, e.hit);
        @(posedge clk);
        e.strobe_t = $time;
        expect_q.push_back(e);
        issued++;
        rd      <= ~is_wr;
        wr      <= is_wr;
        addr    <= a;
        data_in <= d;
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
        waited = 0;
        while (done_count < issued && waited < access_limit) begin
            @(negedge clk);
            waited++;
        end
        assert (done_count == issued)
            else abort_run($sformatf("Request to %h issued at %0t never received done", a,
                                     e.strobe_t));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare at each done
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (done) begin
            assert (expect_q.size() != 0)
                else abort_run($sformatf("done pulsed at %0t with no request pending", $time));
            head = expect_q.pop_front();
            if (!head.is_wr) begin
                assert (data_out === head.data)
                    else abort_run($sformatf("Mismatch at %0t: load %h gave %h, expected %h",
                                             $time, head.addr, data_out, head.data));
            end
            assert (cache_hit === head.hit)
                else abort_run($sformatf("Mismatch at %0t: %h cache_hit %b, expected %b",
                                         $time, head.addr, cache_hit, head.hit));
            assert (stall === 1'b1)
                else abort_run($sformatf("Mismatch at %0t: stall low while %h completes",
                                         $time, head.addr));
            if (head.timed) begin
                latency = int'(($time - head.strobe_t) / clk_period);
                assert (latency == 2)
                    else abort_run($sformatf("Mismatch at %0t: hit done after %0d cycles",
                                             $time, latency));
            end
            done_count++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int               r_op;
        int               r_tag;
        int               r_index;
        int               r_word;
        logic [data_w-1:0] r_data;
        reset   = 1'b1;
        rd      = 1'b0;
        wr      = 1'b0;
        addr    = '0;
        data_in = '0;
        clear_model();
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        repeat (idle_cycles) begin              // Quiet outputs before any strobe
            @(negedge clk);
            assert (!done && !stall && !cache_hit)
                else abort_run($sformatf("Mismatch at %0t: output active after reset", $time));
        end

        run_access(1'b0, 16'h0100, '0, 1'b0);   // Cold miss, then timed hit
        run_access(1'b0, 16'h0100, '0, 1'b1);
        run_access(1'b1, 16'h0204, 16'hbeef, 1'b0);
        run_access(1'b0, 16'h0204, '0, 1'b0);
        run_access(1'b1, 16'h0206, 16'h1234, 1'b0);
        run_access(1'b0, 16'h0206, '0, 1'b0);

        // Three tags on one index push a dirty victim
        for (int t = 1; t <= 3; t++) run_access(1'b1, make_addr(t, 8'h10, 0), 16'h1000 + t, 1'b0);
        for (int t = 1; t <= 3; t++) run_access(1'b0, make_addr(t, 8'h10, 0), '0, 1'b0);

        // Full line written, evicted, refilled
        for (int w = 0; w < 4; w++) run_access(1'b1, make_addr(4, 8'h20, w), 16'ha0a0 + w, 1'b0);
        for (int t = 5; t <= 7; t++) run_access(1'b0, make_addr(t, 8'h20, 0), '0, 1'b0);
        for (int w = 0; w < 4; w++) run_access(1'b0, make_addr(4, 8'h20, w), '0, 1'b0);

        for (int i = 0; i < random_accesses; i++) begin
            r_op    = $random(seed) & 1;
            r_tag   = $random(seed) & 3;
            r_index = 8'h30 + ($random(seed) & 1);
            r_word  = $random(seed) & 3;
            r_data  = 16'($random(seed));
            run_access(r_op[0], make_addr(r_tag, r_index, r_word), r_data, 1'b0);
        end

        // Back to idle with no stray done
        repeat (idle_cycles) @(negedge clk);
        if (done_count == issued && !done && !stall && !cache_hit) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run($sformatf("DUT not idle after %0d done pulses for %0d requests",
                                done_count, issued));
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run($sformatf("Timeout after %0d cycles", watchdog_cycles));
    end

endmodule

/* flist.f */
+incdir+verification
source/mem_sys_pkg.sv
source/request_latch.sv
source/cache_way.sv
source/cache_controller.sv
source/four_bank_mem.sv
source/mem_sys.sv
verification/mem_sys_tb.sv

/* Bender.yml */
package:
  name: mem_sys

sources:
  - files:
      - source/mem_sys_pkg.sv
      - source/request_latch.sv
      - source/cache_way.sv
      - source/cache_controller.sv
      - source/four_bank_mem.sv
      - source/mem_sys.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mem_sys_tb.sv
